//--- verilog.f
+incdir+include
logic/renderPkg.sv
logic/objectTable.sv
logic/objectSnapshot.sv
logic/hitScan.sv
logic/colorStage.sv
logic/rendererTop.sv
verification/rendererTb.sv

//--- include/rendererModel.svh
`ifndef RENDERER_MODEL_SVH
`define RENDERER_MODEL_SVH

import renderPkg::*;

// Next value of one slot location after a clock edge
function automatic logic [LocWidth-1:0] nextLoc(
	input logic rst,
	input logic gameScen,
	input logic [LocWidth-1:0] held,
	input logic [LocWidth-1:0] incoming
);
	if (rst)
		return '0;
	return gameScen ? incoming : held;
endfunction

// Same for a slot kind
function automatic logic [KindWidth-1:0] nextKind(
	input logic rst,
	input logic gameScen,
	input logic [KindWidth-1:0] held,
	input logic [KindWidth-1:0] incoming
);
	if (rst)
		return KindEmpty;
	return gameScen ? incoming : held;
endfunction

function automatic bit spriteCovers(
	input logic [LocWidth-1:0] loc,
	input logic [ScanWidth-1:0] hCount
);
	int left;
	left = int'(loc) + int'(SpriteOffset);
	return (int'(hCount) >= left) && (int'(hCount) < left + int'(SpriteWidth));
endfunction

// First occupied covering slot, units before enemies
function automatic logic [KindWidth-1:0] firstHitKind(
	input logic [LocWidth-1:0] unitLoc [SlotCount],
	input logic [KindWidth-1:0] unitKind [SlotCount],
	input logic [LocWidth-1:0] enemyLoc [SlotCount],
	input logic [KindWidth-1:0] enemyKind [SlotCount],
	input logic [ScanWidth-1:0] vCount,
	input logic [ScanWidth-1:0] hCount
);
	if ((vCount < BandTop) || (vCount > BandBottom))
		return KindEmpty;
	for (int i = 0; i < SlotCount; i++)
		if ((unitKind[i] != KindEmpty) && spriteCovers(unitLoc[i], hCount))
			return unitKind[i];
	for (int i = 0; i < SlotCount; i++)
		if ((enemyKind[i] != KindEmpty) && spriteCovers(enemyLoc[i], hCount))
			return enemyKind[i];
	return KindEmpty;
endfunction

function automatic logic [ColorWidth-1:0] expectedColor(
	input logic bright,
	input logic [ScanWidth-1:0] vCount,
	input logic [KindWidth-1:0] kind
);
	if (!bright)
		return BlankColor;
	case (kind)
		KindWidth'(1): return ColorKind1;
		KindWidth'(2): return ColorKind2;
		KindWidth'(3): return ColorKind3;
		default: return (vCount > BandBottom) ? GroundColor : SkyColor;
	endcase
endfunction

`endif

//--- verification/rendererTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rendererModel.svh"

module rendererTb
	import renderPkg::*;
();

	localparam int CycleLimit = 10000;  // Roughly twice the length of all tests

	logic clk;
	logic rst;
	logic bright;
	logic [ScanWidth-1:0] hCount;
	logic [ScanWidth-1:0] vCount;
	logic gameScen;
	logic [LocWidth-1:0] unitLoc [SlotCount];
	logic [KindWidth-1:0] unitKind [SlotCount];
	logic [LocWidth-1:0] enemyLoc [SlotCount];
	logic [KindWidth-1:0] enemyKind [SlotCount];
	logic [ColorWidth-1:0] rgb;

	// Reference copy of the slot table
	logic [LocWidth-1:0] modelUnitLoc [SlotCount];
	logic [KindWidth-1:0] modelUnitKind [SlotCount];
	logic [LocWidth-1:0] modelEnemyLoc [SlotCount];
	logic [KindWidth-1:0] modelEnemyKind [SlotCount];

	logic [ColorWidth-1:0] expQueue [$];
	logic [ScanWidth-1:0] hQueue [$];
	logic [ScanWidth-1:0] vQueue [$];

	int seed = 9;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int testChecks = 0;
	int testErrors = 0;

	rendererTop UUT
	(
		.clk(clk),
		.rst(rst),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.gameScen(gameScen),
		.unitLoc(unitLoc),
		.unitKind(unitKind),
		.enemyLoc(enemyLoc),
		.enemyKind(enemyKind),
		.rgb(rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic int randRange(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % (hi - lo + 1));
	endfunction

	// Expected value for the pixel sampled at this edge, then the table update of the same edge
	always @(posedge clk)
	begin
		logic [ColorWidth-1:0] expRgb;
		if (rst)
			expRgb = BlankColor;
		else
			expRgb = expectedColor(bright, vCount, firstHitKind(modelUnitLoc, modelUnitKind,
				modelEnemyLoc, modelEnemyKind, vCount, hCount));
		expQueue.push_back(expRgb);
		hQueue.push_back(hCount);
		vQueue.push_back(vCount);
		for (int i = 0; i < SlotCount; i++)
		begin
			modelUnitLoc[i] = nextLoc(rst, gameScen, modelUnitLoc[i], unitLoc[i]);
			modelUnitKind[i] = nextKind(rst, gameScen, modelUnitKind[i], unitKind[i]);
			modelEnemyLoc[i] = nextLoc(rst, gameScen, modelEnemyLoc[i], enemyLoc[i]);
			modelEnemyKind[i] = nextKind(rst, gameScen, modelEnemyKind[i], enemyKind[i]);
		end
		cycleCount++;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// rgb after edge m belongs to the pixel sampled at edge m-1
	always @(negedge clk)
	begin
		logic [ColorWidth-1:0] expRgb;
		logic [ScanWidth-1:0] h;
		logic [ScanWidth-1:0] v;
		if (expQueue.size() >= 2)
		begin
			expRgb = expQueue.pop_front();
			h = hQueue.pop_front();
			v = vQueue.pop_front();
			checkCount++;
			assert (rgb === expRgb)
			else
			begin
				errorCount++;
				$display("MISMATCH at %0t: pixel h=%0d v=%0d gave rgb %h, expected %h",
					$time, h, v, rgb, expRgb);
			end
		end
	end

	task automatic drivePixel(input logic b, input int h, input int v);
		@(posedge clk);
		bright <= b;
		hCount <= ScanWidth'(h);
		vCount <= ScanWidth'(v);
		gameScen <= 1'b0;
	endtask

	// New random slot inputs, with or without a game tick
	task automatic scrambleSlots(input int locMax, input logic tick);
		@(posedge clk);
		for (int i = 0; i < SlotCount; i++)
		begin
			unitLoc[i] <= LocWidth'(randRange(0, locMax));
			unitKind[i] <= KindWidth'(randRange(0, 3));
			enemyLoc[i] <= LocWidth'(randRange(0, locMax));
			enemyKind[i] <= KindWidth'(randRange(0, 3));
		end
		gameScen <= tick;
	endtask

	task automatic startTest();
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	// Let the last pixels drain before counting
	task automatic endTest(input string name);
		repeat (3) @(posedge clk);
		testCount++;
		$display("Test %0d (%s): %0d checks, %0d errors", testCount, name,
			checkCount - testChecks, errorCount - testErrors);
	endtask

	initial
	begin
		rst = 1'b1;
		bright = 1'b0;
		hCount = '0;
		vCount = '0;
		gameScen = 1'b0;
		for (int i = 0; i < SlotCount; i++)
		begin
			unitLoc[i] = '0;
			unitKind[i] = KindEmpty;
			enemyLoc[i] = '0;
			enemyKind[i] = KindEmpty;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		startTest();
		repeat (100)
			drivePixel(1'b0, randRange(0, 1023), randRange(0, 1023));
		scrambleSlots(511, 1'b0);  // Inputs move but no tick yet
		repeat (200)
			drivePixel(1'b1, randRange(195, 730), randRange(380, 400));
		endTest("reset and empty table");

		startTest();
		repeat (5)
		begin
			scrambleSlots(511, 1'b1);
			repeat (100)
				drivePixel(1'b0, randRange(195, 730), randRange(380, 400));
		end
		endTest("blanking");

		// Narrow location range packs many sprites over each other
		startTest();
		repeat (10)
		begin
			scrambleSlots(40, 1'b1);
			repeat (200)
				drivePixel(1'b1, randRange(195, 258), randRange(BandTop, BandBottom));
		end
		endTest("priority and colour");

		startTest();
		@(posedge clk);
		for (int i = 0; i < SlotCount; i++)
		begin
			unitKind[i] <= KindEmpty;
			enemyKind[i] <= KindEmpty;
		end
		unitLoc[3] <= LocWidth'(100);
		unitKind[3] <= KindWidth'(2);
		enemyLoc[0] <= LocWidth'(100);
		enemyKind[0] <= KindWidth'(1);
		gameScen <= 1'b1;
		for (int i = 0; i < 10; i++)
			drivePixel(1'b1, 303 + i, 390);
		@(posedge clk);
		unitKind[3] <= KindWidth'(3);  // Held off until the next tick
		enemyKind[0] <= KindEmpty;
		for (int i = 0; i < 10; i++)
			drivePixel(1'b1, 303 + i, 390);
		@(posedge clk);
		gameScen <= 1'b1;
		for (int i = 0; i < 10; i++)
			drivePixel(1'b1, 303 + i, 390);
		endTest("snapshot hold");

		startTest();
		repeat (10)
		begin
			scrambleSlots(511, 1'b1);
			repeat (150)
				drivePixel(1'b1, randRange(0, 800), randRange(360, 430));
		end
		endTest("background split");

		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
			errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/rendererTop.sv
`timescale 1ns/100ps
`default_nettype none

module rendererTop
	import renderPkg::*;
(
	input wire clk,
	input wire rst,
	input wire bright,
	input wire [ScanWidth-1:0] hCount,
	input wire [ScanWidth-1:0] vCount,
	input wire gameScen,
	input wire [LocWidth-1:0] unitLoc [SlotCount],
	input wire [KindWidth-1:0] unitKind [SlotCount],
	input wire [LocWidth-1:0] enemyLoc [SlotCount],
	input wire [KindWidth-1:0] enemyKind [SlotCount],
	output logic [ColorWidth-1:0] rgb
);

	// Stage 1 to stage 2
	logic [ScanWidth-1:0] stageVCount;
	logic stageBright;
	logic [KindWidth-1:0] stageKind;

	objectTable tableBus ();

	objectSnapshot snapshot
	(
		.clk(clk),
		.rst(rst),
		.gameScen(gameScen),
		.unitLoc(unitLoc),
		.unitKind(unitKind),
		.enemyLoc(enemyLoc),
		.enemyKind(enemyKind),
		.slotTable(tableBus.writer)
	);

	hitScan scan
	(
		.clk(clk),
		.rst(rst),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.slotTable(tableBus.reader),
		.stageVCount(stageVCount),
		.stageBright(stageBright),
		.stageKind(stageKind)
	);

	colorStage color
	(
		.clk(clk),
		.rst(rst),
		.stageVCount(stageVCount),
		.stageBright(stageBright),
		.stageKind(stageKind),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

//--- logic/colorStage.sv
`timescale 1ns/100ps
`default_nettype none

module colorStage
	import renderPkg::*;
(
	input wire clk,
	input wire rst,
	input wire [ScanWidth-1:0] stageVCount,
	input wire stageBright,
	input wire [KindWidth-1:0] stageKind,
	output logic [ColorWidth-1:0] rgb
);

	logic [ColorWidth-1:0] background;
	logic [ColorWidth-1:0] pixelColor;

	// Sky down to the last band line, ground below
	always_comb
	begin
		if (stageVCount > BandBottom)
			background = GroundColor;
		else
			background = SkyColor;
	end

	always_comb
	begin
		case (stageKind)
			KindWidth'(1): pixelColor = ColorKind1;
			KindWidth'(2): pixelColor = ColorKind2;
			KindWidth'(3): pixelColor = ColorKind3;
			default: pixelColor = background;  // Empty kind shows through
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rgb <= BlankColor;
		else if (!stageBright)
			rgb <= BlankColor;
		else
			rgb <= pixelColor;
	end

endmodule

`default_nettype wire

//--- logic/hitScan.sv
`timescale 1ns/100ps
`default_nettype none

module hitScan
	import renderPkg::*;
(
	input wire clk,
	input wire rst,
	input wire bright,
	input wire [ScanWidth-1:0] hCount,
	input wire [ScanWidth-1:0] vCount,
	objectTable.reader slotTable,
	output logic [ScanWidth-1:0] stageVCount,
	output logic stageBright,
	output logic [KindWidth-1:0] stageKind  // KindEmpty when no sprite won
);

	logic inBand;
	logic [SlotCount-1:0] unitHit;
	logic [SlotCount-1:0] enemyHit;
	logic [KindWidth-1:0] winKind;

	// True when col falls on the ten columns of a sprite at loc
	function automatic logic spanHit(
		input logic [LocWidth-1:0] loc,
		input logic [ScanWidth-1:0] col
	);
		logic [ScanWidth-1:0] spanLeft;
		logic [ScanWidth-1:0] spanRight;
		spanLeft = ScanWidth'(loc) + SpriteOffset;  // Cannot wrap, loc tops out at 511
		spanRight = spanLeft + SpriteWidth - ScanWidth'(1);
		return (col >= spanLeft) && (col <= spanRight);
	endfunction

	always_comb
	begin
		inBand = (vCount >= BandTop) && (vCount <= BandBottom);
	end

	// All 32 compares run side by side
	always_comb
	begin
		for (int i = 0; i < SlotCount; i++)
		begin
			unitHit[i] = (slotTable.unitKind[i] != KindEmpty)
				&& spanHit(slotTable.unitLoc[i], hCount);
			enemyHit[i] = (slotTable.enemyKind[i] != KindEmpty)
				&& spanHit(slotTable.enemyLoc[i], hCount);
		end
	end

	// Walk from the lowest priority up so the last match standing wins.
	// Enemies first, then units on top of them.
	always_comb
	begin
		winKind = KindEmpty;
		for (int i = SlotCount - 1; i >= 0; i--)
		begin
			if (enemyHit[i])
				winKind = slotTable.enemyKind[i];
		end
		for (int i = SlotCount - 1; i >= 0; i--)
		begin
			if (unitHit[i])
				winKind = slotTable.unitKind[i];
		end
		if (!inBand)
			winKind = KindEmpty;  // No sprites off the band
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stageBright <= 1'b0;
			stageKind <= KindEmpty;
		end
		else
		begin
			stageBright <= bright;
			stageKind <= winKind;
		end
	end

	// Line number only feeds the background choice
	always_ff @(posedge clk)
	begin
		stageVCount <= vCount;
	end

endmodule

`default_nettype wire

//--- logic/objectSnapshot.sv
`timescale 1ns/100ps
`default_nettype none

module objectSnapshot
	import renderPkg::*;
(
	input wire clk,
	input wire rst,
	input wire gameScen,  // Game tick
	input wire [LocWidth-1:0] unitLoc [SlotCount],
	input wire [KindWidth-1:0] unitKind [SlotCount],
	input wire [LocWidth-1:0] enemyLoc [SlotCount],
	input wire [KindWidth-1:0] enemyKind [SlotCount],
	objectTable.writer slotTable
);

	// Whole table loads at once on a tick, so a frame never mixes two game states
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < SlotCount; i++)
			begin
				slotTable.unitLoc[i] <= '0;
				slotTable.unitKind[i] <= KindEmpty;
				slotTable.enemyLoc[i] <= '0;
				slotTable.enemyKind[i] <= KindEmpty;
			end
		end
		else if (gameScen)
		begin
			for (int i = 0; i < SlotCount; i++)
			begin
				slotTable.unitLoc[i] <= unitLoc[i];
				slotTable.unitKind[i] <= unitKind[i];
				slotTable.enemyLoc[i] <= enemyLoc[i];
				slotTable.enemyKind[i] <= enemyKind[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/objectTable.sv
`timescale 1ns/100ps
`default_nettype none

// Captured slot table, written by the snapshot and read by the scan stage
interface objectTable
	import renderPkg::*;
();

	logic [LocWidth-1:0] unitLoc [SlotCount];
	logic [KindWidth-1:0] unitKind [SlotCount];
	logic [LocWidth-1:0] enemyLoc [SlotCount];
	logic [KindWidth-1:0] enemyKind [SlotCount];

	modport writer
	(
		output unitLoc,
		output unitKind,
		output enemyLoc,
		output enemyKind
	);

	modport reader
	(
		input unitLoc,
		input unitKind,
		input enemyLoc,
		input enemyKind
	);

endinterface

`default_nettype wire

//--- logic/renderPkg.sv
`default_nettype none

package renderPkg;

	// Slot table
	localparam int SlotCount = 16;  // Objects per side
	localparam int LocWidth = 9;
	localparam int KindWidth = 2;
	localparam logic [KindWidth-1:0] KindEmpty = 2'd0;

	// Scan counters
	localparam int ScanWidth = 10;

	// Colour word is 4 bits each of red, green, blue
	localparam int ColorWidth = 12;

	localparam logic [ColorWidth-1:0] ColorKind1 = 12'hF00;  // Red
	localparam logic [ColorWidth-1:0] ColorKind2 = 12'h0F0;  // Green
	localparam logic [ColorWidth-1:0] ColorKind3 = 12'h00F;  // Blue

	// Sprite band, inclusive on both lines
	localparam logic [ScanWidth-1:0] BandTop = 10'd386;
	localparam logic [ScanWidth-1:0] BandBottom = 10'd395;

	// Location 0 sits at this screen column
	localparam logic [ScanWidth-1:0] SpriteOffset = 10'd203;
	localparam logic [ScanWidth-1:0] SpriteWidth = 10'd10;

	// Background split at the bottom line of the band
	localparam logic [ColorWidth-1:0] SkyColor = 12'h37B;
	localparam logic [ColorWidth-1:0] GroundColor = 12'h2D2;

	localparam logic [ColorWidth-1:0] BlankColor = 12'h000;  // Outside the visible area

endpackage

`default_nettype wire
